//--- Bender.yml
package:
  name: spikecnt

sources:
  - spikecnt_pkg.sv
  - tick_gen.sv
  - waveform_store.sv
  - spike_counter.sv
  - count_readout.sv
  - spikecnt_top.sv
  - target: test
    files:
      - spikecnt_sva.sv
      - spikecnt_tb.sv

//--- count_readout.sv
`timescale 1ns/1ps
`default_nettype none

module count_readout
    import spikecnt_pkg::*;
#(
    parameter int unsigned NUM_CHAN = NUM_CHAN_DEF
)
(
    input  wire                ep50trig,
    input  wire                reset_global,
    input  wire count_report_s reports [NUM_CHAN],
    // host pops one channel per strobe
    input  wire                read_strobe,
    output logic               new_window,
    // sticky, a window was lost before it was drained
    output logic               overrun,
    output cnt_t               read_count
);

    localparam int unsigned IDX_W = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_CHAN - 1);

    cnt_t             bank [NUM_CHAN];
    logic [IDX_W-1:0] rd_idx;
    logic             any_done;

    // counters close together, any done bit marks the window
    always_comb
    begin
        any_done = 1'b0;
        for (int c = 0; c < NUM_CHAN; c++)
        begin
            any_done |= reports[c].done;
        end
    end

    //////////////////////////////////////////////////
    // count bank
    //////////////////////////////////////////////////

    // cleared so read_count is 0 out of reset
    always_ff @(posedge ep50trig)
    begin
        for (int c = 0; c < NUM_CHAN; c++)
        begin
            if (reset_global)
            begin
                bank[c] <= '0;
            end
            else if (reports[c].done)
            begin
                bank[c] <= reports[c].count;
            end
        end
    end

    //////////////////////////////////////////////////
    // drain control
    //////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            rd_idx     <= '0;
            new_window <= 1'b0;
            overrun    <= 1'b0;
        end
        else if (any_done)
        begin
            // no back-pressure, newest window wins
            rd_idx     <= '0;
            new_window <= 1'b1;
            if (new_window)
            begin
                overrun <= 1'b1;
            end
        end
        else if (read_strobe && new_window)
        begin
            if (rd_idx == LAST_IDX)
            begin
                rd_idx     <= '0;
                new_window <= 1'b0;
            end
            else
            begin
                rd_idx <= rd_idx + 1'b1;
            end
        end
    end

    assign read_count = bank[rd_idx];

endmodule

`default_nettype wire

//--- spike_counter.sv
`timescale 1ns/1ps
`default_nettype none

module spike_counter
    import spikecnt_pkg::*;
#(
    // which bit of beat.spikes this counter watches
    parameter int unsigned CHAN = 0
)
(
    input  wire              ep50trig,
    input  wire              reset_global,
    input  wire spike_beat_s beat,
    output count_report_s    report
);

    // sum of the window so far
    cnt_t run_cnt;
    // total of the last closed window
    cnt_t total_q;
    logic done_q;
    logic spike_bit;
    logic closing;

    assign spike_bit = beat.spikes[CHAN];
    // window_end only ever comes with a strobe, checked anyway
    assign closing   = beat.strobe && beat.window_end;

    //////////////////////////////////////////////////
    // running count
    //////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            run_cnt <= '0;
            done_q  <= 1'b0;
        end
        else if (closing)
        begin
            // next beat opens a fresh window
            run_cnt <= '0;
            done_q  <= 1'b1;
        end
        else
        begin
            done_q <= 1'b0;
            if (beat.strobe)
            begin
                run_cnt <= run_cnt + cnt_t'(spike_bit);
            end
        end
    end

    // closing beat belongs to the window it closes
    always_ff @(posedge ep50trig)
    begin
        if (closing)
        begin
            total_q <= run_cnt + cnt_t'(spike_bit);
        end
    end

    assign report = '{count: total_q, done: done_q};

endmodule

`default_nettype wire

//--- spikecnt_pkg.sv
`default_nettype none

package spikecnt_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    // spike total of one channel over one window
    typedef logic [31:0] cnt_t;

    // divider half count, host value zero-extended from 16 bits
    typedef logic [17:0] half_cnt_t;

    // one word as the host sends it
    typedef logic [15:0] host_word_t;

    // one waveform element, bit c is the spike of channel c
    typedef logic [31:0] element_t;

    //////////////////////////////////////////////////
    // bundles
    //////////////////////////////////////////////////

    // one playback beat, fanned out to every counter
    typedef struct packed {
        element_t spikes;
        // new beat this cycle
        logic     strobe;
        // this beat is the last of its window
        logic     window_end;
    } spike_beat_s;

    // per-channel result of a closed window
    typedef struct packed {
        cnt_t count;
        // high for one cycle when count is valid
        logic done;
    } count_report_s;

    //////////////////////////////////////////////////
    // default parameter values
    //////////////////////////////////////////////////

    // channel count, 1 to 32
    localparam int unsigned NUM_CHAN_DEF       = 4;
    // table depth in elements
    localparam int unsigned DEPTH_DEF          = 16;
    // beats per counting window
    localparam int unsigned WINDOW_TICKS_DEF   = 8;
    // divider half count out of reset
    localparam int unsigned RESET_HALF_CNT_DEF = 3;

endpackage

`default_nettype wire

//--- spikecnt_sva.sv
`timescale 1ns/1ps
`default_nettype none

module spikecnt_sva
    import spikecnt_pkg::*;
(
    input wire            ep50trig,
    input wire            reset_global,
    input wire            sim_tick,
    // divider setting inside tick_gen
    input wire half_cnt_t half_cnt,
    input wire            new_window,
    input wire            overrun,
    input wire            read_strobe,
    // counters close together, channel 0 stands for all
    input wire            window_done,
    input wire cnt_t      read_count
);

    //////////////////////////////////////////////////
    // tick enable
    //////////////////////////////////////////////////

    // only half count 0 gives a tick every cycle
    tick_spacing_a : assert property (
        @(posedge ep50trig) disable iff (reset_global)
            (sim_tick && half_cnt != '0) |=> !sim_tick
    ) else $error("sim_tick high on two consecutive cycles");

    //////////////////////////////////////////////////
    // readout
    //////////////////////////////////////////////////

    reset_quiet_a : assert property (
        @(posedge ep50trig) reset_global |=> (!new_window && !overrun)
    ) else $error("new_window or overrun set during reset");

    // bank and index hold while the host is not reading
    read_hold_a : assert property (
        @(posedge ep50trig) disable iff (reset_global)
            (new_window && !read_strobe && !window_done) |=> $stable(read_count)
    ) else $error("read_count changed with no read strobe");

endmodule

bind spikecnt_top spikecnt_sva sva_i (
    .ep50trig     (ep50trig),
    .reset_global (reset_global),
    .sim_tick     (sim_tick),
    .half_cnt     (tick_gen_i.half_cnt),
    .new_window   (new_window),
    .overrun      (overrun),
    .read_strobe  (read_strobe),
    .window_done  (reports[0].done),
    .read_count   (read_count)
);

`default_nettype wire

//--- spikecnt_tb.sv
`timescale 1ns/1ps
`default_nettype none

module spikecnt_tb
    import spikecnt_pkg::*;
();

    localparam int unsigned NUM_CHAN       = 4;
    localparam int unsigned DEPTH          = 16;
    localparam int unsigned WINDOW_TICKS   = 8;
    localparam int unsigned RESET_HALF_CNT = 3;
    localparam int unsigned NUM_RATES      = 3;
    // 4 at reset rate, 2 per table rate, 2 around repop, 2 for overrun
    localparam int unsigned NUM_WINDOWS    = 4 + 2 * NUM_RATES + 2 + 2;
    // reset, two words per element, slack
    localparam int unsigned LOAD_CYCLES    = 8 + 2 * DEPTH + 4;

    logic       ep50trig;
    logic       reset_global;
    logic       rate_load;
    host_word_t rate_value;
    logic       feed_valid;
    host_word_t feed_data;
    logic       repop;
    logic       read_strobe;
    logic       sim_tick;
    logic       done_feeding;
    logic       new_window;
    logic       overrun;
    cnt_t       read_count;

    // waveform table, filled from the seeded generator
    element_t   elem_tab [DEPTH];
    // half counts to step through, kept above 0 so a drain fits in a window
    host_word_t rate_tab [NUM_RATES] = '{16'd1, 16'd3, 16'd5};
    int         seed;
    int         errors;
    // first element of the window being counted
    int         win_start;

    spikecnt_top #(
        .NUM_CHAN       (NUM_CHAN),
        .DEPTH          (DEPTH),
        .WINDOW_TICKS   (WINDOW_TICKS),
        .RESET_HALF_CNT (RESET_HALF_CNT)
    ) dut_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .rate_load    (rate_load),
        .rate_value   (rate_value),
        .feed_valid   (feed_valid),
        .feed_data    (feed_data),
        .repop        (repop),
        .read_strobe  (read_strobe),
        .sim_tick     (sim_tick),
        .done_feeding (done_feeding),
        .new_window   (new_window),
        .overrun      (overrun),
        .read_count   (read_count)
    );

    // 4 ns period
    initial
    begin
        ep50trig = 1'b0;
    end

    always #2 ep50trig = ~ep50trig;

    //////////////////////////////////////////////////
    // reference model and checker
    //////////////////////////////////////////////////

    // spikes of one channel over WINDOW_TICKS elements, wrapping at DEPTH
    function automatic cnt_t window_count(input int start, input int chan);
        cnt_t n;
        n = '0;
        for (int k = 0; k < WINDOW_TICKS; k++)
        begin
            n += cnt_t'(elem_tab[(start + k) % DEPTH][chan]);
        end
        return n;
    endfunction

    // slowest divider setting the run will see
    function automatic int max_half();
        int m;
        m = RESET_HALF_CNT;
        for (int r = 0; r < NUM_RATES; r++)
        begin
            if (int'(rate_tab[r]) > m)
            begin
                m = rate_tab[r];
            end
        end
        return m;
    endfunction

    task automatic check_value(input string what, input cnt_t got, input cnt_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
            errors++;
            $display("TESTBENCH FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    //////////////////////////////////////////////////
    // host side sequences
    //////////////////////////////////////////////////

    // two words per element, low word first
    task automatic feed_table();
        host_word_t word;
        for (int i = 0; i < 2 * DEPTH; i++)
        begin
            word = (i % 2 == 1) ? elem_tab[i / 2][31:16] : elem_tab[i / 2][15:0];
            @(posedge ep50trig);
            feed_valid <= 1'b1;
            feed_data  <= word;
        end
        // 31 words taken so far
        @(negedge ep50trig);
        check_value("done_feeding after 31 words", cnt_t'(done_feeding), 0);
        @(posedge ep50trig);
        feed_valid <= 1'b0;
        @(negedge ep50trig);
        check_value("done_feeding after 32 words", cnt_t'(done_feeding), 1);
    endtask

    // returns on the falling edge where new_window is first seen high
    task automatic wait_window();
        do
        begin
            @(negedge ep50trig);
        end
        while (!new_window);
    endtask

    // one read strobe per channel, checked against the model
    task automatic drain_window(input int start);
        check_value("new_window before drain", cnt_t'(new_window), 1);
        for (int c = 0; c < NUM_CHAN; c++)
        begin
            check_value($sformatf("read_count chan %0d from element %0d", c, start),
                        read_count, window_count(start, c));
            @(posedge ep50trig);
            read_strobe <= 1'b1;
            @(posedge ep50trig);
            read_strobe <= 1'b0;
            @(negedge ep50trig);
        end
        check_value("new_window after drain", cnt_t'(new_window), 0);
    endtask

    task automatic load_rate(input host_word_t value);
        @(posedge ep50trig);
        rate_load  <= 1'b1;
        rate_value <= value;
        @(posedge ep50trig);
        rate_load  <= 1'b0;
    endtask

    // cycles between two consecutive sim_tick pulses
    task automatic check_tick_spacing(input int half);
        int gap;
        gap = 0;
        do
        begin
            @(negedge ep50trig);
        end
        while (!sim_tick);
        do
        begin
            @(negedge ep50trig);
            gap++;
        end
        while (!sim_tick);
        check_value($sformatf("sim_tick spacing at half count %0d", half),
                    cnt_t'(gap), cnt_t'(half + 1));
    endtask

    task automatic issue_repop();
        @(posedge ep50trig);
        repop <= 1'b1;
        @(posedge ep50trig);
        repop <= 1'b0;
        @(negedge ep50trig);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial
    begin : stimulus
        errors       = 0;
        seed         = 32'hc0c8;
        reset_global = 1'b1;
        rate_load    = 1'b0;
        rate_value   = '0;
        feed_valid   = 1'b0;
        feed_data    = '0;
        repop        = 1'b0;
        read_strobe  = 1'b0;
        for (int i = 0; i < DEPTH; i++)
        begin
            elem_tab[i] = $random(seed);
        end

        repeat (8) @(posedge ep50trig);
        reset_global <= 1'b0;
        @(negedge ep50trig);
        // outputs right out of reset
        check_value("sim_tick after reset", cnt_t'(sim_tick), 0);
        check_value("done_feeding after reset", cnt_t'(done_feeding), 0);
        check_value("new_window after reset", cnt_t'(new_window), 0);
        check_value("overrun after reset", cnt_t'(overrun), 0);
        check_value("read_count after reset", read_count, 0);

        feed_table();

        // consecutive windows at the reset rate
        win_start = 0;
        for (int w = 0; w < 4; w++)
        begin
            wait_window();
            drain_window(win_start);
            win_start = (win_start + WINDOW_TICKS) % DEPTH;
        end

        // rate changes, playback position carries on
        for (int r = 0; r < NUM_RATES; r++)
        begin
            load_rate(rate_tab[r]);
            check_tick_spacing(rate_tab[r]);
            for (int w = 0; w < 2; w++)
            begin
                wait_window();
                drain_window(win_start);
                win_start = (win_start + WINDOW_TICKS) % DEPTH;
            end
        end

        // repop right after a close, before the next tick
        // closing window starts at element 0, so playback would go on at 8
        wait_window();
        issue_repop();
        drain_window(win_start);
        win_start = 0;
        wait_window();
        drain_window(win_start);
        win_start = (win_start + WINDOW_TICKS) % DEPTH;

        // two closes with no reads in between
        wait_window();
        check_value("overrun before second close", cnt_t'(overrun), 0);
        do
        begin
            @(negedge ep50trig);
        end
        while (!overrun);
        win_start = (win_start + WINDOW_TICKS) % DEPTH;
        drain_window(win_start);
        check_value("overrun stays set", cnt_t'(overrun), 1);

        if (errors == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // bound on run length, doubled for slack
    initial
    begin : watchdog
        int limit;
        limit = 2 * (NUM_WINDOWS * WINDOW_TICKS * (max_half() + 1) + LOAD_CYCLES);
        repeat (limit) @(posedge ep50trig);
        $display("timeout: DUT did not reach the expected state within %0d cycles", limit);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- spikecnt_top.sv
`timescale 1ns/1ps
`default_nettype none

module spikecnt_top
    import spikecnt_pkg::*;
#(
    parameter int unsigned NUM_CHAN       = NUM_CHAN_DEF,
    parameter int unsigned DEPTH          = DEPTH_DEF,
    parameter int unsigned WINDOW_TICKS   = WINDOW_TICKS_DEF,
    parameter int unsigned RESET_HALF_CNT = RESET_HALF_CNT_DEF
)
(
    input  wire             ep50trig,
    input  wire             reset_global,
    // rate setting
    input  wire             rate_load,
    input  wire host_word_t rate_value,
    // waveform load and restart
    input  wire             feed_valid,
    input  wire host_word_t feed_data,
    input  wire             repop,
    // count drain
    input  wire             read_strobe,
    output wire             sim_tick,
    output wire             done_feeding,
    output wire             new_window,
    output wire             overrun,
    output wire cnt_t       read_count
);

    // beat fanned out to all counters
    spike_beat_s   beat;
    // one report per channel
    count_report_s reports [NUM_CHAN];

    //////////////////////////////////////////////////
    // tick source and waveform feeder
    //////////////////////////////////////////////////

    tick_gen #(
        .RESET_HALF_CNT (RESET_HALF_CNT)
    ) tick_gen_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .rate_load    (rate_load),
        .rate_value   (rate_value),
        .sim_tick     (sim_tick)
    );

    waveform_store #(
        .NUM_CHAN     (NUM_CHAN),
        .DEPTH        (DEPTH),
        .WINDOW_TICKS (WINDOW_TICKS)
    ) waveform_store_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .feed_valid   (feed_valid),
        .feed_data    (feed_data),
        .repop        (repop),
        .sim_tick     (sim_tick),
        .done_feeding (done_feeding),
        .beat         (beat)
    );

    //////////////////////////////////////////////////
    // counter array and readout
    //////////////////////////////////////////////////

    // one counter per channel bit
    for (genvar c = 0; c < NUM_CHAN; c++)
    begin : chan_g
        spike_counter #(
            .CHAN (c)
        ) spike_counter_i (
            .ep50trig     (ep50trig),
            .reset_global (reset_global),
            .beat         (beat),
            .report       (reports[c])
        );
    end

    count_readout #(
        .NUM_CHAN (NUM_CHAN)
    ) count_readout_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .reports      (reports),
        .read_strobe  (read_strobe),
        .new_window   (new_window),
        .overrun      (overrun),
        .read_count   (read_count)
    );

endmodule

`default_nettype wire

//--- tb.f
spikecnt_pkg.sv
tick_gen.sv
waveform_store.sv
spike_counter.sv
count_readout.sv
spikecnt_top.sv
spikecnt_sva.sv
spikecnt_tb.sv

//--- tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tick_gen
    import spikecnt_pkg::*;
#(
    parameter int unsigned RESET_HALF_CNT = RESET_HALF_CNT_DEF
)
(
    input  wire             ep50trig,
    input  wire             reset_global,
    // host loads a new rate
    input  wire             rate_load,
    input  wire host_word_t rate_value,
    // one-cycle enable, every half_cnt+1 cycles
    output logic            sim_tick
);

    //////////////////////////////////////////////////
    // rate register
    //////////////////////////////////////////////////

    // current half count
    half_cnt_t half_cnt;
    // cycles left until the next tick
    half_cnt_t down_cnt;

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            half_cnt <= half_cnt_t'(RESET_HALF_CNT);
        end
        else if (rate_load)
        begin
            // zero-extend host value
            half_cnt <= half_cnt_t'(rate_value);
        end
    end

    //////////////////////////////////////////////////
    // divider
    //////////////////////////////////////////////////

    // down-counter restarts from the new value on reset or load,
    // so first tick lands half_cnt+1 cycles after either
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            down_cnt <= half_cnt_t'(RESET_HALF_CNT);
            sim_tick <= 1'b0;
        end
        else if (rate_load)
        begin
            down_cnt <= half_cnt_t'(rate_value);
            sim_tick <= 1'b0;
        end
        else if (down_cnt == '0)
        begin
            // wrap, reload and fire
            down_cnt <= half_cnt;
            sim_tick <= 1'b1;
        end
        else
        begin
            down_cnt <= down_cnt - 1'b1;
            sim_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- waveform_store.sv
`timescale 1ns/1ps
`default_nettype none

module waveform_store
    import spikecnt_pkg::*;
#(
    parameter int unsigned NUM_CHAN     = NUM_CHAN_DEF,
    parameter int unsigned DEPTH        = DEPTH_DEF,
    parameter int unsigned WINDOW_TICKS = WINDOW_TICKS_DEF
)
(
    input  wire             ep50trig,
    input  wire             reset_global,
    // host word stream, low word of each element first
    input  wire             feed_valid,
    input  wire host_word_t feed_data,
    // restart playback at element 0
    input  wire             repop,
    input  wire             sim_tick,
    output logic            done_feeding,
    output spike_beat_s     beat
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned WIN_W = (WINDOW_TICKS > 1) ? $clog2(WINDOW_TICKS) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [WIN_W-1:0] LAST_WIN = WIN_W'(WINDOW_TICKS - 1);
    // only the low NUM_CHAN bits reach the counters
    localparam element_t CHAN_MASK = element_t'((64'd1 << NUM_CHAN) - 64'd1);

    // loading side
    host_word_t       low_half;
    logic             hi_phase;
    logic [PTR_W-1:0] wr_ptr;
    element_t         wave_mem [DEPTH];
    logic             feed_take;

    // playback side
    logic [PTR_W-1:0] play_ptr;
    logic [WIN_W-1:0] win_pos;
    logic             play_take;
    element_t         beat_spikes;
    logic             beat_strobe;
    logic             beat_end;

    // feed words count only until the table is full
    assign feed_take = feed_valid && !done_feeding;
    assign play_take = sim_tick && done_feeding && !repop;

    //////////////////////////////////////////////////
    // table fill
    //////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            hi_phase     <= 1'b0;
            wr_ptr       <= '0;
            done_feeding <= 1'b0;
        end
        else if (feed_take)
        begin
            hi_phase <= ~hi_phase;
            if (hi_phase)
            begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
                // last element written, table locked until reset
                if (wr_ptr == LAST_PTR)
                begin
                    done_feeding <= 1'b1;
                end
            end
        end
    end

    // low word parks here until its high word arrives
    always_ff @(posedge ep50trig)
    begin
        if (feed_take)
        begin
            if (!hi_phase)
            begin
                low_half <= feed_data;
            end
            else
            begin
                wave_mem[wr_ptr] <= {feed_data, low_half};
            end
        end
    end

    //////////////////////////////////////////////////
    // playback
    //////////////////////////////////////////////////

    // counters keep their running sums across repop,
    // so the host issues it right after a window closes
    always_ff @(posedge ep50trig)
    begin
        if (reset_global || repop)
        begin
            play_ptr    <= '0;
            win_pos     <= '0;
            beat_strobe <= 1'b0;
            beat_end    <= 1'b0;
        end
        else if (play_take)
        begin
            beat_strobe <= 1'b1;
            beat_end    <= (win_pos == LAST_WIN);
            play_ptr    <= (play_ptr == LAST_PTR) ? '0 : play_ptr + 1'b1;
            win_pos     <= (win_pos == LAST_WIN) ? '0 : win_pos + 1'b1;
        end
        else
        begin
            beat_strobe <= 1'b0;
            beat_end    <= 1'b0;
        end
    end

    // element payload, qualified by beat_strobe
    always_ff @(posedge ep50trig)
    begin
        if (play_take)
        begin
            beat_spikes <= wave_mem[play_ptr] & CHAN_MASK;
        end
    end

    assign beat = '{spikes: beat_spikes, strobe: beat_strobe, window_end: beat_end};

endmodule

`default_nettype wire
